//--- spec_store.f
hdl/spec_store_pkg.sv
hdl/data_mem.sv
hdl/mem_arbiter.sv
hdl/store_unit.sv
hdl/load_unit.sv
hdl/rewind_queue.sv
hdl/spec_store_top.sv
testbench/spec_store_assertions.sv
testbench/spec_store_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = spec_store_tb
FILELIST   = spec_store.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run itself may stop early, the log decides pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/spec_store_tests.txt
# cmd addr size data tag  (hex; size 0 byte, 1 half, 2 word; data is the expected value on L)
# S store, B store into a full queue, L load, R retire, X resteer, W wait until idle
S 010 2 11223344 001
R 000 0 00000000 001
L 010 2 11223344 000
L 011 0 00000033 000
S 020 2 aaaa5555 002
R 000 0 00000000 002
S 020 2 deadbeef 003
S 020 2 01020304 004
L 020 2 01020304 000
X 000 0 00000000 000
L 020 2 aaaa5555 000
S 030 2 a1b2c3d4 005
R 000 0 00000000 005
S 031 0 000000ee 006
S 032 1 0000face 007
L 030 2 faceeed4 000
X 000 0 00000000 000
L 030 2 a1b2c3d4 000
L 033 0 000000a1 000
L 032 1 0000a1b2 000
L 010 2 11223344 000
S 040 2 12345678 008
S 040 1 00009999 009
L 040 2 12349999 000
R 000 0 00000000 008
X 000 0 00000000 000
L 040 2 12345678 000
S 100 2 5a000100 00a
S 104 2 5a000104 00b
S 108 2 5a000108 00c
S 10c 2 5a00010c 00d
S 110 2 5a000110 00e
S 114 2 5a000114 00f
S 118 2 5a000118 010
S 11c 2 5a00011c 011
B 120 2 cafe0120 012
R 000 0 00000000 00a
W 000 0 00000000 000
L 120 2 cafe0120 000
L 100 2 5a000100 000
X 000 0 00000000 000
L 100 2 5a000100 000
L 104 2 00000000 000
L 11c 2 00000000 000
L 120 2 00000000 000
W 000 0 00000000 000

//--- testbench/spec_store_tb.sv
`timescale 1ns/1ps

module spec_store_tb import spec_store_pkg::*; ();

    localparam int TAG_WIDTH  = 10;
    localparam int Q_DEPTH    = 8;
    localparam int ADDR_WIDTH = 10;
    localparam int TIMEOUT    = 200;  // Cycles per wait
    localparam int HOLD       = 12;   // Cycles a blocked store is watched

    logic                  clk;
    logic                  rst;
    logic                  st_req;
    logic [ADDR_WIDTH-1:0] st_addr;
    logic [31:0]           st_data;
    access_size_t          st_size;
    logic [TAG_WIDTH-1:0]  st_tag;
    logic                  st_busy;
    logic                  ld_req;
    logic [ADDR_WIDTH-1:0] ld_addr;
    access_size_t          ld_size;
    logic                  ld_valid;
    logic [31:0]           ld_data;
    logic                  ld_busy;
    logic                  ret_valid;
    logic [TAG_WIDTH-1:0]  ret_tag;
    logic                  resteer;
    logic                  restoring;
    logic                  rewind_full;

    // Reference memory and the stores not yet retired in program order
    logic [7:0]            ref_mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] open_addr [$];
    int                    open_len  [$];
    logic [31:0]           open_old  [$];
    logic [TAG_WIDTH-1:0]  open_tag  [$];
    int                    loads_checked;

    spec_store_top #(
        .TAG_WIDTH(TAG_WIDTH),
        .Q_DEPTH(Q_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_spec_store_top (
        .clk(clk), .rst(rst), .st_req(st_req), .st_addr(st_addr), .st_data(st_data),
        .st_size(st_size), .st_tag(st_tag), .st_busy(st_busy), .ld_req(ld_req),
        .ld_addr(ld_addr), .ld_size(ld_size), .ld_valid(ld_valid), .ld_data(ld_data),
        .ld_busy(ld_busy), .ret_valid(ret_valid), .ret_tag(ret_tag), .resteer(resteer),
        .restoring(restoring), .rewind_full(rewind_full)
    );

    bind spec_store_top spec_store_assertions u_assertions (
        .clk(clk), .rst(rst), .push(push), .rewind_full(rewind_full),
        .restoring(restoring), .st_busy(st_busy), .rs_grant(rs_grant),
        .st_grant(st_grant), .ld_grant(ld_grant)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    function automatic int bytes_of(input logic [1:0] size);
        case (size)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    // Byte i of a little endian access lives at addr + i
    task automatic apply_store(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] size,
                               input logic [31:0] data, input logic [TAG_WIDTH-1:0] tag);
        logic [31:0]           old;
        logic [ADDR_WIDTH-1:0] a;
        old = '0;
        for (int i = 0; i < bytes_of(size); i++) begin
            a = addr + i[ADDR_WIDTH-1:0];
            old[8*i +: 8] = ref_mem[a];
            ref_mem[a]    = data[8*i +: 8];
        end
        open_addr.push_back(addr);
        open_len.push_back(bytes_of(size));
        open_old.push_back(old);
        open_tag.push_back(tag);
    endtask

    function automatic logic [31:0] ref_load(input logic [ADDR_WIDTH-1:0] addr,
                                             input logic [1:0] size);
        logic [31:0]           val;
        logic [ADDR_WIDTH-1:0] a;
        val = '0;
        for (int i = 0; i < bytes_of(size); i++) begin
            a = addr + i[ADDR_WIDTH-1:0];
            val[8*i +: 8] = ref_mem[a];
        end
        return val;
    endfunction

    task automatic drop_retired(input logic [TAG_WIDTH-1:0] tag);
        assert (open_tag.size() > 0 && open_tag[0] == tag)
            else stop_on_error($sformatf("retire of tag %h is not the oldest open store", tag));
        open_addr.delete(0);
        open_len.delete(0);
        open_old.delete(0);
        open_tag.delete(0);
    endtask

    // Undo youngest first like the rewind queue
    task automatic undo_speculation();
        logic [ADDR_WIDTH-1:0] base;
        logic [ADDR_WIDTH-1:0] a;
        logic [31:0]           old;
        int                    len;
        while (open_tag.size() > 0) begin
            base = open_addr.pop_back();
            len  = open_len.pop_back();
            old  = open_old.pop_back();
            open_tag.delete(open_tag.size() - 1);
            for (int i = 0; i < len; i++) begin
                a = base + i[ADDR_WIDTH-1:0];
                ref_mem[a] = old[8*i +: 8];
            end
        end
    endtask

    task automatic issue_store(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] size,
                               input logic [31:0] data, input logic [TAG_WIDTH-1:0] tag);
        assert (!restoring) else stop_on_error("store issued while memory is being restored");
        @(posedge clk);
        st_req  <= 1'b1;
        st_addr <= addr;
        st_size <= access_size_t'(size);
        st_data <= data;
        st_tag  <= tag;
        @(posedge clk);
        st_req <= 1'b0;
    endtask

    task automatic wait_store_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else stop_on_error("timeout waiting for st_busy to fall");
        end while (st_busy);
    endtask

    task automatic hold_blocked_store();
        repeat (HOLD) begin
            @(negedge clk);
            assert (st_busy && rewind_full)
                else stop_on_error("store went ahead while the rewind queue was full");
        end
    endtask

    task automatic run_load(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] size,
                            input logic [31:0] expected);
        logic [31:0] model_val;
        int          cycles;
        model_val = ref_load(addr, size);
        @(posedge clk);
        ld_req  <= 1'b1;
        ld_addr <= addr;
        ld_size <= access_size_t'(size);
        @(posedge clk);
        ld_req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else stop_on_error("timeout waiting for ld_valid");
        end while (!ld_valid);
        assert (ld_data === expected) else report_mismatch("ld_data", ld_data, expected);
        assert (ld_data === model_val)
            else report_mismatch("ld_data against the reference model", ld_data, model_val);
        loads_checked++;
    endtask

    task automatic send_retire(input logic [TAG_WIDTH-1:0] tag);
        @(posedge clk);
        ret_valid <= 1'b1;
        ret_tag   <= tag;
        @(posedge clk);
        ret_valid <= 1'b0;
    endtask

    task automatic send_resteer();
        logic had_open;
        int   cycles;
        assert (!st_busy) else stop_on_error("resteer requested while a store is in flight");
        had_open = (open_tag.size() > 0);
        undo_speculation();
        @(posedge clk);
        resteer <= 1'b1;
        @(posedge clk);
        resteer <= 1'b0;
        @(negedge clk);
        assert (restoring == had_open)
            else report_mismatch("restoring", {31'd0, restoring}, {31'd0, had_open});
        cycles = 0;
        while (restoring) begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else stop_on_error("timeout waiting for restoring to fall");
        end
        assert (!rewind_full) else report_mismatch("rewind_full", 32'd1, 32'd0);
    endtask

    task automatic wait_all_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (st_busy || ld_busy || restoring) begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else stop_on_error("timeout waiting for the DUT to go idle");
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        byte         cmd;
        logic [31:0] f_addr;
        logic [31:0] f_size;
        logic [31:0] f_data;
        logic [31:0] f_tag;
        clk       = 1'b0;
        rst       = 1'b1;
        st_req    = 1'b0;
        st_addr   = '0;
        st_data   = '0;
        st_size   = SZ_WORD;
        st_tag    = '0;
        ld_req    = 1'b0;
        ld_addr   = '0;
        ld_size   = SZ_WORD;
        ret_valid = 1'b0;
        ret_tag   = '0;
        resteer   = 1'b0;
        loads_checked = 0;
        foreach (ref_mem[i]) ref_mem[i] = 8'h00; // Memory clears on reset

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!st_busy && !ld_busy && !ld_valid && !restoring && !rewind_full)
            else stop_on_error("DUT outputs not idle after reset");

        fd = $fopen("testbench/spec_store_tests.txt", "r");
        assert (fd != 0) else stop_on_error("cannot open testbench/spec_store_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cmd    = line.getc(0);
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                             f_addr, f_size, f_data, f_tag);
            assert (fields == 4) else stop_on_error($sformatf("bad test line: %s", line));
            case (cmd)
                "S": begin
                    apply_store(f_addr[ADDR_WIDTH-1:0], f_size[1:0], f_data, f_tag[TAG_WIDTH-1:0]);
                    issue_store(f_addr[ADDR_WIDTH-1:0], f_size[1:0], f_data, f_tag[TAG_WIDTH-1:0]);
                    wait_store_done();
                end
                "B": begin
                    assert (rewind_full)
                        else stop_on_error("rewind queue not full before the blocked store");
                    apply_store(f_addr[ADDR_WIDTH-1:0], f_size[1:0], f_data, f_tag[TAG_WIDTH-1:0]);
                    issue_store(f_addr[ADDR_WIDTH-1:0], f_size[1:0], f_data, f_tag[TAG_WIDTH-1:0]);
                    hold_blocked_store();
                end
                "L": run_load(f_addr[ADDR_WIDTH-1:0], f_size[1:0], f_data);
                "R": begin
                    drop_retired(f_tag[TAG_WIDTH-1:0]);
                    send_retire(f_tag[TAG_WIDTH-1:0]);
                end
                "X": send_resteer();
                "W": wait_all_idle();
                default: stop_on_error($sformatf("unknown command in test line: %s", line));
            endcase
        end
        $fclose(fd);

        if (loads_checked > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("the test file held no load to check");
        end
    end

endmodule

//--- testbench/spec_store_assertions.sv
`timescale 1ns/1ps

module spec_store_assertions (
    input logic clk,
    input logic rst,
    input logic push,
    input logic rewind_full,
    input logic restoring,
    input logic st_busy,
    input logic rs_grant,
    input logic st_grant,
    input logic ld_grant
);

    // Store unit holds its write while the queue has no room
    assert property (@(posedge clk) disable iff (rst) push |-> !rewind_full)
        else $error("push into a full rewind queue");

    assert property (@(posedge clk) disable iff (rst) $onehot0({rs_grant, st_grant, ld_grant}))
        else $error("memory port granted to more than one requester");

    assert property (@(posedge clk) $fell(rst) |-> !restoring && !rewind_full && !st_busy)
        else $error("store path not idle when reset is released");

endmodule

//--- hdl/spec_store_top.sv
`timescale 1ns/1ps

module spec_store_top import spec_store_pkg::*; #(
    parameter int TAG_WIDTH  = 10,
    parameter int Q_DEPTH    = 8,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st_req,
    input  logic [ADDR_WIDTH-1:0] st_addr,
    input  logic [31:0]           st_data,
    input  access_size_t          st_size,
    input  logic [TAG_WIDTH-1:0]  st_tag,
    output logic                  st_busy,
    input  logic                  ld_req,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    input  access_size_t          ld_size,
    output logic                  ld_valid,
    output logic [31:0]           ld_data,
    output logic                  ld_busy,
    input  logic                  ret_valid,
    input  logic [TAG_WIDTH-1:0]  ret_tag,
    input  logic                  resteer,
    output logic                  restoring,
    output logic                  rewind_full
);

    logic                  st_mem_req, st_grant;
    mem_op_t               st_mem_op;
    logic [ADDR_WIDTH-1:0] st_mem_addr;
    logic [31:0]           st_mem_wdata;
    access_size_t          st_mem_size;
    logic                  ld_mem_req, ld_grant;
    logic [ADDR_WIDTH-1:0] ld_mem_addr;
    logic                  rs_req, rs_grant;
    logic [ADDR_WIDTH-1:0] rs_addr;
    logic [31:0]           rs_wdata;
    access_size_t          rs_size;
    logic                  push;
    logic [ADDR_WIDTH-1:0] push_addr;
    logic [31:0]           push_old;
    access_size_t          push_size;
    logic [TAG_WIDTH-1:0]  push_tag;
    mem_op_t               mem_op;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [31:0]           mem_wdata, mem_rdata;
    access_size_t          mem_size;

    store_unit #(.TAG_WIDTH(TAG_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_store_unit (
        .clk(clk), .rst(rst), .st_req(st_req), .st_addr(st_addr), .st_data(st_data),
        .st_size(st_size), .st_tag(st_tag), .grant(st_grant), .mem_rdata(mem_rdata),
        .rewind_full(rewind_full), .st_busy(st_busy), .req(st_mem_req), .req_op(st_mem_op),
        .req_addr(st_mem_addr), .req_wdata(st_mem_wdata), .req_size(st_mem_size),
        .push(push), .push_addr(push_addr), .push_old(push_old), .push_size(push_size),
        .push_tag(push_tag)
    );

    load_unit #(.ADDR_WIDTH(ADDR_WIDTH)) u_load_unit (
        .clk(clk), .rst(rst), .ld_req(ld_req), .ld_addr(ld_addr), .ld_size(ld_size),
        .grant(ld_grant), .mem_rdata(mem_rdata), .ld_busy(ld_busy), .req(ld_mem_req),
        .req_addr(ld_mem_addr), .ld_valid(ld_valid), .ld_data(ld_data)
    );

    rewind_queue #(.TAG_WIDTH(TAG_WIDTH), .Q_DEPTH(Q_DEPTH), .ADDR_WIDTH(ADDR_WIDTH))
    u_rewind_queue (
        .clk(clk), .rst(rst), .push(push), .push_addr(push_addr), .push_old(push_old),
        .push_size(push_size), .push_tag(push_tag), .ret_valid(ret_valid),
        .ret_tag(ret_tag), .resteer(resteer), .grant(rs_grant), .rewind_full(rewind_full),
        .restoring(restoring), .req(rs_req), .req_addr(rs_addr), .req_wdata(rs_wdata),
        .req_size(rs_size)
    );

    // Restores only write, loads only read whole words
    mem_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem_arbiter (
        .clk(clk), .rst(rst),
        .rs_req(rs_req), .rs_op(OP_WRITE), .rs_addr(rs_addr), .rs_wdata(rs_wdata),
        .rs_size(rs_size),
        .st_req(st_mem_req), .st_op(st_mem_op), .st_addr(st_mem_addr),
        .st_wdata(st_mem_wdata), .st_size(st_mem_size),
        .ld_req(ld_mem_req), .ld_op(OP_READ), .ld_addr(ld_mem_addr), .ld_wdata(32'd0),
        .ld_size(SZ_WORD),
        .rs_grant(rs_grant), .st_grant(st_grant), .ld_grant(ld_grant),
        .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_size(mem_size)
    );

    data_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_data_mem (
        .clk(clk), .rst(rst), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_size(mem_size), .mem_rdata(mem_rdata)
    );

endmodule

//--- hdl/rewind_queue.sv
`timescale 1ns/1ps

module rewind_queue import spec_store_pkg::*; #(
    parameter int TAG_WIDTH  = 10,
    parameter int Q_DEPTH    = 8,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [ADDR_WIDTH-1:0] push_addr,
    input  logic [31:0]           push_old,
    input  access_size_t          push_size,
    input  logic [TAG_WIDTH-1:0]  push_tag,
    input  logic                  ret_valid,
    input  logic [TAG_WIDTH-1:0]  ret_tag,
    input  logic                  resteer,
    input  logic                  grant,
    output logic                  rewind_full,
    output logic                  restoring,
    output logic                  req,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic [31:0]           req_wdata,
    output access_size_t          req_size
);

    localparam int PTR_W = $clog2(Q_DEPTH);

    // Entry payload
    logic [ADDR_WIDTH-1:0] e_addr [Q_DEPTH];
    logic [31:0]           e_old  [Q_DEPTH];
    access_size_t          e_size [Q_DEPTH];
    logic [TAG_WIDTH-1:0]  e_tag  [Q_DEPTH];

    logic [Q_DEPTH-1:0] valid;
    logic [Q_DEPTH-1:0] retired;
    logic [Q_DEPTH-1:0] flushed;
    logic [PTR_W-1:0]   head;      // Oldest entry
    logic [PTR_W-1:0]   tail;      // Next free slot
    logic [PTR_W-1:0]   youngest;
    logic               head_pop;
    logic               tail_pop;

    assign youngest = tail - 1'b1;

    assign head_pop = valid[head] && retired[head];   // No memory access needed
    assign tail_pop = req && grant;

    assign rewind_full = &valid;
    assign restoring   = |(valid & flushed);

    // Unretired stores are the youngest ones, so the tail is always flushed first
    assign req       = valid[youngest] && flushed[youngest];
    assign req_addr  = e_addr[youngest];
    assign req_wdata = e_old[youngest];
    assign req_size  = e_size[youngest];

    always_ff @(posedge clk) begin
        if (push) begin
            e_addr[tail] <= push_addr;
            e_old[tail]  <= push_old;
            e_size[tail] <= push_size;
            e_tag[tail]  <= push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            retired <= '0;
            flushed <= '0;
            head    <= '0;
            tail    <= '0;
        end else begin
            for (int i = 0; i < Q_DEPTH; i++) begin
                if (ret_valid && valid[i] && !flushed[i] && e_tag[i] == ret_tag) begin
                    retired[i] <= 1'b1;
                end
                if (resteer && valid[i] && !retired[i]) begin
                    flushed[i] <= 1'b1; // Whole speculative window at once
                end
            end
            if (head_pop) begin
                valid[head]   <= 1'b0;
                retired[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            if (tail_pop) begin
                valid[youngest]   <= 1'b0;
                flushed[youngest] <= 1'b0;
                tail              <= youngest; // Step back toward older stores
            end
            if (push) begin
                valid[tail]   <= 1'b1;
                retired[tail] <= 1'b0;
                flushed[tail] <= 1'b0;
                tail          <= tail + 1'b1;
            end
        end
    end

endmodule

//--- hdl/load_unit.sv
`timescale 1ns/1ps

module load_unit import spec_store_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ld_req,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    input  access_size_t          ld_size,
    input  logic                  grant,
    input  logic [31:0]           mem_rdata,
    output logic                  ld_busy,
    output logic                  req,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic                  ld_valid,
    output logic [31:0]           ld_data
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_REQ,
        L_DATA
    } state_t;

    state_t                state;
    logic [ADDR_WIDTH-1:0] addr_q;
    access_size_t          size_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= L_IDLE;
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= (state == L_DATA);
            case (state)
                L_IDLE:  if (ld_req) state <= L_REQ;
                L_REQ:   if (grant) state <= L_DATA;
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == L_IDLE && ld_req) begin
            addr_q <= ld_addr;
            size_q <= ld_size;
        end
        // Shift the addressed lanes down, zero-extend
        if (state == L_DATA) begin
            ld_data <= (mem_rdata >> {addr_q[1:0], 3'b000}) & lane_bits(size_q, 2'b00);
        end
    end

    assign ld_busy  = (state != L_IDLE);
    assign req      = (state == L_REQ);
    assign req_addr = addr_q;

endmodule

//--- hdl/store_unit.sv
`timescale 1ns/1ps

module store_unit import spec_store_pkg::*; #(
    parameter int TAG_WIDTH  = 10,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st_req,
    input  logic [ADDR_WIDTH-1:0] st_addr,
    input  logic [31:0]           st_data,
    input  access_size_t          st_size,
    input  logic [TAG_WIDTH-1:0]  st_tag,
    input  logic                  grant,
    input  logic [31:0]           mem_rdata,
    input  logic                  rewind_full,
    output logic                  st_busy,
    output logic                  req,
    output mem_op_t               req_op,
    output logic [ADDR_WIDTH-1:0] req_addr,
    output logic [31:0]           req_wdata,
    output access_size_t          req_size,
    output logic                  push,
    output logic [ADDR_WIDTH-1:0] push_addr,
    output logic [31:0]           push_old,
    output access_size_t          push_size,
    output logic [TAG_WIDTH-1:0]  push_tag
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,   // Old word requested
        S_WAIT,   // Read data arriving
        S_WRITE   // New data requested
    } state_t;

    state_t                state;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [31:0]           data_q;
    logic [31:0]           old_q;
    access_size_t          size_q;
    logic [TAG_WIDTH-1:0]  tag_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (st_req) state <= S_READ;
                S_READ:  if (grant) state <= S_WAIT;
                S_WAIT:  state <= S_WRITE;
                S_WRITE: if (grant) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && st_req) begin
            addr_q <= st_addr;
            data_q <= st_data << {st_addr[1:0], 3'b000}; // Move into byte lanes
            size_q <= st_size;
            tag_q  <= st_tag;
        end
        if (state == S_WAIT) begin
            old_q <= mem_rdata & lane_bits(size_q, addr_q[1:0]); // Keep only bytes we overwrite
        end
    end

    assign st_busy = (state != S_IDLE);

    // Write held back while the queue has no room for the old data
    assign req = (state == S_READ) || (state == S_WRITE && !rewind_full);

    always_comb begin
        case (state)
            S_READ:  req_op = OP_READ;
            S_WRITE: req_op = OP_WRITE;
            default: req_op = OP_IDLE;
        endcase
    end

    assign req_addr  = addr_q;
    assign req_wdata = data_q;
    assign req_size  = size_q;

    assign push      = grant && (state == S_WRITE); // Same cycle as the memory write
    assign push_addr = addr_q;
    assign push_old  = old_q;
    assign push_size = size_q;
    assign push_tag  = tag_q;

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import spec_store_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    // Restore writes from the rewind queue
    input  logic                  rs_req,
    input  mem_op_t               rs_op,
    input  logic [ADDR_WIDTH-1:0] rs_addr,
    input  logic [31:0]           rs_wdata,
    input  access_size_t          rs_size,
    // Store unit
    input  logic                  st_req,
    input  mem_op_t               st_op,
    input  logic [ADDR_WIDTH-1:0] st_addr,
    input  logic [31:0]           st_wdata,
    input  access_size_t          st_size,
    // Load unit
    input  logic                  ld_req,
    input  mem_op_t               ld_op,
    input  logic [ADDR_WIDTH-1:0] ld_addr,
    input  logic [31:0]           ld_wdata,
    input  access_size_t          ld_size,
    output logic                  rs_grant,
    output logic                  st_grant,
    output logic                  ld_grant,
    output mem_op_t               mem_op,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    output access_size_t          mem_size
);

    logic rs_ok;
    logic st_ok;
    logic ld_ok;

    // A requester still holds its request in its grant cycle, so skip it once
    assign rs_ok = rs_req && !rs_grant;
    assign st_ok = st_req && !st_grant;
    assign ld_ok = ld_req && !ld_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_grant <= 1'b0;
            st_grant <= 1'b0;
            ld_grant <= 1'b0;
            mem_op   <= OP_IDLE;
        end else begin
            rs_grant <= rs_ok;
            st_grant <= st_ok && !rs_ok;
            ld_grant <= ld_ok && !rs_ok && !st_ok;
            if (rs_ok) mem_op <= rs_op;
            else if (st_ok) mem_op <= st_op;
            else if (ld_ok) mem_op <= ld_op;
            else mem_op <= OP_IDLE;
        end
    end

    // Winner's payload travels with its grant
    always_ff @(posedge clk) begin
        if (rs_ok) begin
            mem_addr  <= rs_addr;
            mem_wdata <= rs_wdata;
            mem_size  <= rs_size;
        end else if (st_ok) begin
            mem_addr  <= st_addr;
            mem_wdata <= st_wdata;
            mem_size  <= st_size;
        end else if (ld_ok) begin
            mem_addr  <= ld_addr;
            mem_wdata <= ld_wdata;
            mem_size  <= ld_size;
        end
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem import spec_store_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_op_t               mem_op,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [31:0]           mem_wdata,
    input  access_size_t          mem_size,
    output logic [31:0]           mem_rdata
);

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [31:0]           mem [WORDS];
    logic [ADDR_WIDTH-3:0] word;
    logic [3:0]            lanes;

    assign word  = mem_addr[ADDR_WIDTH-1:2];
    assign lanes = byte_lanes(mem_size, mem_addr[1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
            mem_rdata <= '0;
        end else if (mem_op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) mem[word][8*b +: 8] <= mem_wdata[8*b +: 8]; // Only selected lanes
            end
        end else if (mem_op == OP_READ) begin
            mem_rdata <= mem[word]; // Whole word, requester extracts
        end
    end

endmodule

//--- hdl/spec_store_pkg.sv
package spec_store_pkg;

    // Operation on the shared memory port
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_t;

    // Width of a naturally aligned access
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_size_t;

    // Byte enables of an aligned access within its word
    function automatic logic [3:0] byte_lanes(access_size_t size, logic [1:0] lo);
        case (size)
            SZ_BYTE: byte_lanes = 4'b0001 << lo;
            SZ_HALF: byte_lanes = 4'b0011 << {lo[1], 1'b0};
            default: byte_lanes = 4'b1111;
        endcase
    endfunction

    // Same lanes expanded to a bit mask
    function automatic logic [31:0] lane_bits(access_size_t size, logic [1:0] lo);
        logic [3:0] lanes;
        lanes = byte_lanes(size, lo);
        for (int b = 0; b < 4; b++) begin
            lane_bits[8*b +: 8] = {8{lanes[b]}};
        end
    endfunction

endpackage
